// File: Bender.yml
package:
  name: phase_cpu

export_include_dirs:
  - include

sources:
  - files:
      - hw/phase_cpu_pkg.sv
      - hw/phase_sched.sv
      - hw/inst_decode.sv
      - hw/alu_unit.sv
      - hw/reg_file.sv
      - hw/mem_port.sv
      - hw/phase_cpu.sv
  - target: simulation
    files:
      - sim/tb_phase_cpu.sv

// File: hw/alu_unit.sv
`timescale 1ns/100ps
`include "phase_cpu_params.svh"

module alu_unit
   import phase_cpu_pkg::*;
(
   input  inst_kind_t kind_i,
   input  alu_op_t    alu_op_i,
   input  logic       flag_set_i,
   input  word_t      op_a_i,
   input  word_t      op_b_i,
   input  word_t      imm_i,
   input  flags_t     flags_i,
   output word_t      result_o,
   output flags_t     flags_o,
   output logic       wb_en_o,
   output logic       flag_en_o
);

   localparam int MSB = `CPU_WIDTH - 1;

   word_t                b;
   logic [`CPU_WIDTH:0]  sum;  // carry in top bit
   logic [`CPU_WIDTH:0]  diff;
   word_t                res;
   logic                 c;
   logic                 v;
   logic                 valid;
   logic                 writes;
   logic                 is_alu;
   logic                 is_cmp;

   assign is_alu = (kind_i == 3'd0) || (kind_i == 3'd1);
   assign is_cmp = (alu_op_i == 4'd6);

   // immediate form takes rd as first operand, upstream
   assign b = (kind_i == 3'd1) ? imm_i : op_b_i;

   assign sum  = {1'b0, op_a_i} + {1'b0, b};
   assign diff = {1'b0, op_a_i} + {1'b0, ~b} + 1'b1; // top bit set means no borrow

   always_comb
   begin
      res    = '0;
      c      = flags_i[`FLAG_C]; // logic ops keep C and V
      v      = flags_i[`FLAG_V];
      valid  = 1'b1;
      writes = 1'b1;
      case (alu_op_i)
         4'd0: res = b;
         4'd1:
         begin
            res = sum[MSB:0];
            c   = sum[`CPU_WIDTH];
            v   = (op_a_i[MSB] == b[MSB]) && (res[MSB] != op_a_i[MSB]);
         end
         4'd2, 4'd6:
         begin
            res = diff[MSB:0];
            c   = diff[`CPU_WIDTH];
            v   = (op_a_i[MSB] != b[MSB]) && (res[MSB] != op_a_i[MSB]);
            writes = !is_cmp; // cmp only sets flags
         end
         4'd3: res = op_a_i & b;
         4'd4: res = op_a_i | b;
         4'd5: res = op_a_i ^ b;
         4'd7:
         begin
            res = {op_a_i[MSB-1:0], 1'b0};
            c   = op_a_i[MSB]; // bit shifted out
         end
         4'd8:
         begin
            res = {1'b0, op_a_i[MSB:1]};
            c   = op_a_i[0];
         end
         default:
         begin
            valid  = 1'b0;
            writes = 1'b0;
         end
      endcase
   end

   always_comb
   begin
      flags_o          = flags_i;
      flags_o[`FLAG_C] = c;
      flags_o[`FLAG_S] = res[MSB];
      flags_o[`FLAG_Z] = (res == '0);
      flags_o[`FLAG_V] = v;
   end

   assign result_o  = res;
   assign wb_en_o   = is_alu && writes;
   assign flag_en_o = is_alu && valid && (flag_set_i || is_cmp);

endmodule

// File: hw/inst_decode.sv
`timescale 1ns/100ps
`include "phase_cpu_params.svh"

module inst_decode
   import phase_cpu_pkg::*;
(
   input  logic       clk,
   input  logic       reset_i,
   input  phase_t     phase_i,
   input  word_t      mbus_rdata_i,
   input  flags_t     alu_flags_i,
   input  logic       alu_flag_en_i,
   output inst_kind_t kind_o,
   output reg_idx_t   ra_o,
   output reg_idx_t   rb_o,
   output reg_idx_t   rd_o,
   output alu_op_t    alu_op_o,
   output logic       flag_set_o,
   output logic       index_o,
   output word_t      imm16_o,
   output word_t      imm24_o,
   output logic       cond_ok_o,
   output flags_t     flags_o
);

   word_t  ir; // instruction register
   flags_t flags;
   logic   f_c;
   logic   f_s;
   logic   f_z;
   logic   f_v;

   always_ff @(posedge clk)
   begin
      if (reset_i)
         ir <= '0;
      else if (phase_i == PH_FETCH)
         ir <= mbus_rdata_i;
   end

   // flags only move in writeback of an enabled instruction
   always_ff @(posedge clk)
   begin
      if (reset_i)
         flags <= '0;
      else if (phase_i == PH_WB && cond_ok_o && alu_flag_en_i)
         flags <= alu_flags_i;
   end

   assign kind_o     = ir[27:25];
   assign rd_o       = ir[23:20];
   assign ra_o       = ir[19:16];
   assign rb_o       = ir[11:8];
   assign flag_set_o = ir[24];
   assign index_o    = ir[24]; // call index / base writeback

   // register form keeps the op low, immediate form in the ra slot
   assign alu_op_o = (kind_o == 3'd0) ? ir[7:4] : ir[19:16];

   // memory offsets are signed, alu immediates are not
   assign imm16_o = kind_o[2] ? {{16{ir[15]}}, ir[15:0]} : {16'd0, ir[15:0]};

   // call target: absolute imm24 or signed imm20 offset
   assign imm24_o = ir[24] ? {{12{ir[19]}}, ir[19:0]} : {8'd0, ir[23:0]};

   assign f_c = flags[`FLAG_C];
   assign f_s = flags[`FLAG_S];
   assign f_z = flags[`FLAG_Z];
   assign f_v = flags[`FLAG_V];

   always_comb
   begin
      case (ir[31:28])
         4'd1:    cond_ok_o = f_z;                // EQ
         4'd2:    cond_ok_o = !f_z;               // NE
         4'd3:    cond_ok_o = f_c;                // CS
         4'd4:    cond_ok_o = !f_c;               // CC
         4'd5:    cond_ok_o = f_s;                // MI
         4'd6:    cond_ok_o = !f_s;               // PL
         4'd7:    cond_ok_o = f_v;                // VS
         4'd8:    cond_ok_o = !f_v;               // VC
         4'd9:    cond_ok_o = f_c && !f_z;        // HI
         4'd10:   cond_ok_o = !f_c || f_z;        // LS
         4'd11:   cond_ok_o = f_s == f_v;         // GE
         4'd12:   cond_ok_o = f_s != f_v;         // LT
         4'd13:   cond_ok_o = !f_z && (f_s == f_v);
         4'd14:   cond_ok_o = f_z || (f_s != f_v);
         default: cond_ok_o = 1'b1;               // 0 and 15 always
      endcase
   end

   assign flags_o = flags;

endmodule

// File: hw/mem_port.sv
`timescale 1ns/100ps

module mem_port
   import phase_cpu_pkg::*;
(
   input  logic       clk,
   input  phase_t     phase_i,
   input  inst_kind_t kind_i,
   input  logic       cond_ok_i,
   input  logic       base_wr_bit_i,
   input  word_t      ra_data_i,
   input  word_t      rb_data_i,
   input  word_t      rd_data_i,
   input  word_t      imm16_i,     // already sign extended
   input  word_t      pc_i,
   input  word_t      mbus_rdata_i,
   output word_t      mbus_addr_o,
   output word_t      mbus_wdata_o,
   output logic       mbus_wen_o,
   output word_t      ld_addr_o,
   output word_t      ld_data_o
);

   logic  is_mem;
   logic  is_ld;
   logic  is_st;
   word_t offset;
   word_t ea;      // effective address
   word_t ld_data;

   // classes 4..7, bit 0 set is a load, bit 1 set is immediate offset
   assign is_mem = kind_i[2];
   assign is_ld  = is_mem && kind_i[0];
   assign is_st  = is_mem && !kind_i[0];

   assign offset = kind_i[1] ? imm16_i : rb_data_i;
   assign ea     = ra_data_i + offset;

   // bus shows pc except during the data access
   assign mbus_addr_o = (phase_i == PH_MEM && is_mem) ? ea : pc_i;

   assign mbus_wdata_o = rd_data_i;
   assign mbus_wen_o   = (phase_i == PH_MEM) && is_st && cond_ok_i;

   // without the writeback bit ra keeps its own value
   assign ld_addr_o = base_wr_bit_i ? ea : ra_data_i;

   always_ff @(posedge clk)
   begin
      if (phase_i == PH_MEM && is_ld)
         ld_data <= mbus_rdata_i;
   end

   assign ld_data_o = ld_data;

endmodule

// File: hw/phase_cpu.sv
`timescale 1ns/100ps
`include "phase_cpu_params.svh"

module phase_cpu
   import phase_cpu_pkg::*;
(
   input  logic     clk,
   input  logic     reset_i,
   output word_t    mbus_addr_o,
   input  word_t    mbus_rdata_i,
   output word_t    mbus_wdata_o,
   output logic     mbus_wen_o,
   input  reg_idx_t test_rsel_i,
   output word_t    test_reg_o,
   output phase_t   phase_o
);

   phase_t     phase;
   inst_kind_t kind;
   reg_idx_t   ra, rb, rd;
   alu_op_t    alu_op;
   logic       flag_set, index, cond_ok;
   word_t      imm16, imm24;
   flags_t     flags, alu_flags;
   logic       alu_wb_en, alu_flag_en;
   word_t      ra_data, rb_data, rd_data, pc;
   word_t      op_a, alu_res, call_target, ld_addr, ld_data;
   word_t      wb_data;
   reg_idx_t   wb_idx;
   logic       is_call, is_mem, is_ld, wb_en;

   assign is_call = (kind == 3'd2);
   assign is_mem  = kind[2];
   assign is_ld   = kind[2] && kind[0];

   phase_sched u_sched (.clk(clk), .reset_i(reset_i), .phase_o(phase));

   inst_decode u_decode
   (
      .clk(clk), .reset_i(reset_i), .phase_i(phase), .mbus_rdata_i(mbus_rdata_i),
      .alu_flags_i(alu_flags), .alu_flag_en_i(alu_flag_en),
      .kind_o(kind), .ra_o(ra), .rb_o(rb), .rd_o(rd), .alu_op_o(alu_op),
      .flag_set_o(flag_set), .index_o(index), .imm16_o(imm16), .imm24_o(imm24),
      .cond_ok_o(cond_ok), .flags_o(flags)
   );

   assign op_a = (kind == 3'd1) ? rd_data : ra_data; // immediate form works on rd

   alu_unit u_alu
   (
      .kind_i(kind), .alu_op_i(alu_op), .flag_set_i(flag_set), .op_a_i(op_a),
      .op_b_i(rb_data), .imm_i(imm16), .flags_i(flags), .result_o(alu_res),
      .flags_o(alu_flags), .wb_en_o(alu_wb_en), .flag_en_o(alu_flag_en)
   );

   // rd relative call target when indexed
   assign call_target = index ? rd_data + imm24 : imm24;

   assign wb_data = is_call ? call_target : (is_ld ? ld_data : alu_res);
   assign wb_idx  = is_call ? reg_idx_t'(`CPU_PC_REG) : rd;
   assign wb_en   = alu_wb_en || is_call || is_ld;

   reg_file u_regs
   (
      .clk(clk), .reset_i(reset_i), .ra_i(ra), .rb_i(rb), .rd_i(rd),
      .test_rsel_i(test_rsel_i),
      .inc_pc_i(phase == PH_EXEC),
      .link_i(phase == PH_MEM && cond_ok && is_call),
      .base_wr_i(phase == PH_MEM && cond_ok && is_mem),
      .wb_i(phase == PH_WB && cond_ok && wb_en),
      .wb_idx_i(wb_idx), .wb_data_i(wb_data), .base_data_i(ld_addr),
      .ra_data_o(ra_data), .rb_data_o(rb_data), .rd_data_o(rd_data),
      .test_data_o(test_reg_o), .pc_o(pc)
   );

   mem_port u_mem
   (
      .clk(clk), .phase_i(phase), .kind_i(kind), .cond_ok_i(cond_ok),
      .base_wr_bit_i(index), .ra_data_i(ra_data), .rb_data_i(rb_data),
      .rd_data_i(rd_data), .imm16_i(imm16), .pc_i(pc), .mbus_rdata_i(mbus_rdata_i),
      .mbus_addr_o(mbus_addr_o), .mbus_wdata_o(mbus_wdata_o), .mbus_wen_o(mbus_wen_o),
      .ld_addr_o(ld_addr), .ld_data_o(ld_data)
   );

   assign phase_o = phase;

endmodule

// File: hw/phase_cpu_pkg.sv
`include "phase_cpu_params.svh"

package phase_cpu_pkg;

   // one data word, also one bus address
   typedef logic [`CPU_WIDTH-1:0] word_t;

   // register number
   typedef logic [$clog2(`CPU_REG_CNT)-1:0] reg_idx_t;

   // C, S, Z, V packed as in the params header
   typedef logic [3:0] flags_t;

   // alu operation code, from bits 7:4 or 19:16
   typedef logic [3:0] alu_op_t;

   // instruction class, bits 27:25
   typedef logic [2:0] inst_kind_t;

   // one instruction takes all four phases
   typedef enum logic [1:0]
   {
      PH_FETCH = 2'd0,
      PH_EXEC  = 2'd1,
      PH_MEM   = 2'd2,
      PH_WB    = 2'd3
   } phase_t;

endpackage

// File: hw/phase_sched.sv
`timescale 1ns/100ps

module phase_sched
   import phase_cpu_pkg::*;
(
   input  logic   clk,
   input  logic   reset_i,
   output phase_t phase_o
);

   phase_t state;
   phase_t state_nxt;

   // plain rotation, one phase per clock
   always_comb
   begin
      case (state)
         PH_FETCH: state_nxt = PH_EXEC;
         PH_EXEC:  state_nxt = PH_MEM;
         PH_MEM:   state_nxt = PH_WB;
         default:  state_nxt = PH_FETCH;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset_i)
         state <= PH_FETCH;
      else
         state <= state_nxt;
   end

   assign phase_o = state;

endmodule

// File: hw/reg_file.sv
`timescale 1ns/100ps
`include "phase_cpu_params.svh"

module reg_file
   import phase_cpu_pkg::*;
(
   input  logic     clk,
   input  logic     reset_i,
   input  reg_idx_t ra_i,
   input  reg_idx_t rb_i,
   input  reg_idx_t rd_i,
   input  reg_idx_t test_rsel_i,
   input  logic     inc_pc_i,   // exec phase
   input  logic     link_i,     // mem phase, call
   input  logic     base_wr_i,  // mem phase, load/store
   input  logic     wb_i,       // writeback phase
   input  reg_idx_t wb_idx_i,
   input  word_t    wb_data_i,
   input  word_t    base_data_i,
   output word_t    ra_data_o,
   output word_t    rb_data_o,
   output word_t    rd_data_o,
   output word_t    test_data_o,
   output word_t    pc_o
);

   word_t regs [`CPU_REG_CNT];

   // strobes come in different phases, so at most one fires per edge
   always_ff @(posedge clk)
   begin
      if (reset_i)
      begin
         for (int i = 0; i < `CPU_REG_CNT; i++)
            regs[i] <= '0;
      end
      else
      begin
         if (inc_pc_i)
            regs[`CPU_PC_REG] <= regs[`CPU_PC_REG] + 1'b1;
         if (link_i)
            regs[`CPU_LINK_REG] <= regs[`CPU_PC_REG]; // pc already incremented
         if (base_wr_i)
            regs[ra_i] <= base_data_i;
         if (wb_i)
            regs[wb_idx_i] <= wb_data_i;
      end
   end

   assign ra_data_o   = regs[ra_i];
   assign rb_data_o   = regs[rb_i];
   assign rd_data_o   = regs[rd_i];
   assign test_data_o = regs[test_rsel_i];
   assign pc_o        = regs[`CPU_PC_REG];

endmodule

// File: include/phase_cpu_params.svh
`ifndef PHASE_CPU_PARAMS_SVH
`define PHASE_CPU_PARAMS_SVH

// data path and bus width
`define CPU_WIDTH 32

// register file layout
`define CPU_REG_CNT 16
`define CPU_LINK_REG 14 // return address of a call
`define CPU_PC_REG 15   // any write here is a branch

// bit positions inside the flag word
`define FLAG_C 0 // carry, or no-borrow on subtract
`define FLAG_S 1 // sign of result
`define FLAG_Z 2 // result is zero
`define FLAG_V 3 // signed overflow

`endif

// File: phase_cpu.f
+incdir+include
hw/phase_cpu_pkg.sv
hw/phase_sched.sv
hw/inst_decode.sv
hw/alu_unit.sv
hw/reg_file.sv
hw/mem_port.sv
hw/phase_cpu.sv
sim/tb_phase_cpu.sv

// File: sim/phase_cpu_stim.txt
# records: M addr word (memory preload), N count (instructions), B from to (fetch redirect)
# E reg value (final register), S addr data (stores in order); all hex except N
N 33
M 00 02100005  M 01 02200003  M 02 00310210  M 03 01410220  M 04 00530130  # mov add sub and
M 05 025400F0  M 06 00650350  M 07 00760070  M 08 00870080  M 09 0290FFFF  # or xor shifts
M 0A 03910001  M 0B 00010260  M 0C 12A01111  M 0D D2B02222  M 0E 00020160  # cmp, eq fails
M 0F B2C03333  M 10 C2C04444  M 11 02360008  M 12 22310001  M 13 12410010  # ge lt ne eq
M 14 02D00040  M 15 0C3D0002  M 16 096D0200  M 17 0E0DFFFD  M 18 0B1D0200  # loads, stores
M 19 2D1D0000  M 1A 04000030  M 20 0CED0004  M 21 02F00021  # skipped store, call, spin
M 30 0CED0003  M 31 02500050  M 32 055FFFE8  M 38 0EFD0001  # indexed call, load to r15
M 40 CAFE0001  M 46 12345678  M 47 00000020  # data words
B 1A 30  B 32 38  B 38 20  B 21 21
E 0 CAFE0001  E 1 12345678  E 2 00000003  E 3 00000008  E 4 00000012
E 5 00000050  E 6 000000F8  E 7 000001F0  E 8 000000F8  E 9 00010000
E A 00000000  E B 00002222  E C 00004444  E D 00000046  E E 00000033
S 42 00000008  S 43 000000F8  S 49 0000001B  S 4A 00000033

// File: sim/tb_phase_cpu.sv
`timescale 1ns/100ps

module tb_phase_cpu
   import phase_cpu_pkg::*;
();

   logic     clk;
   logic     reset_i;
   word_t    mbus_addr;
   word_t    mbus_rdata;
   word_t    mbus_wdata;
   logic     mbus_wen;
   reg_idx_t test_rsel;
   word_t    test_reg;
   phase_t   phase;

   word_t    mem [256];
   word_t    exp_reg [16];
   logic     exp_valid [16];
   word_t    st_addr_q [$];  // stores in program order
   word_t    st_data_q [$];
   word_t    br_from_q [$];  // fetch redirects
   word_t    br_to_q [$];
   integer   n_inst;
   integer   seed;
   logic     running;

   phase_cpu dut
   (
      .clk(clk), .reset_i(reset_i), .mbus_addr_o(mbus_addr), .mbus_rdata_i(mbus_rdata),
      .mbus_wdata_o(mbus_wdata), .mbus_wen_o(mbus_wen), .test_rsel_i(test_rsel),
      .test_reg_o(test_reg), .phase_o(phase)
   );

   // memory answers in the same cycle
   assign mbus_rdata = mem[mbus_addr[7:0]];

   always @(posedge clk)
   begin
      if (mbus_wen)
         mem[mbus_addr[7:0]] <= mbus_wdata;
   end

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic stop_run();
      $display("Checks failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic expect_word(input string name, input word_t got, input word_t exp);
      assert (got === exp)
      else
      begin
         $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
         stop_run();
      end
   endtask

   // fetch after addr, +1 unless the stim file lists a redirect
   function automatic word_t next_fetch(input word_t addr);
      word_t nxt;
      nxt = addr + 1;
      for (int i = 0; i < br_from_q.size(); i++)
         if (br_from_q[i] == addr)
            nxt = br_to_q[i];
      return nxt;
   endfunction

   task automatic check_store();
      assert (st_addr_q.size() > 0)
      else
      begin
         $display("Unexpected store to address %h at %0t", mbus_addr, $time);
         stop_run();
      end
      expect_word("mbus_addr_o", mbus_addr, st_addr_q.pop_front());
      expect_word("mbus_wdata_o", mbus_wdata, st_data_q.pop_front());
   endtask

   task automatic load_stim();
      integer        fd;
      integer        code;
      logic [7:0]    tag;
      word_t         a;
      word_t         d;
      logic [1023:0] rest;
      fd = $fopen("sim/phase_cpu_stim.txt", "r");
      assert (fd != 0)
      else
      begin
         $display("Could not open the stim file sim/phase_cpu_stim.txt");
         stop_run();
      end
      while ($fscanf(fd, "%s", tag) == 1)
      begin
         if (tag == "#")
            code = $fgets(rest, fd); // rest of line is a comment
         else if (tag == "N")
            code = $fscanf(fd, "%d", n_inst);
         else
         begin
            code = $fscanf(fd, "%h %h", a, d);
            if (tag == "M")
               mem[a[7:0]] = d;
            else if (tag == "E")
            begin
               exp_reg[a[3:0]]   = d;
               exp_valid[a[3:0]] = 1'b1;
            end
            else if (tag == "S")
            begin
               st_addr_q.push_back(a);
               st_data_q.push_back(d);
            end
            else if (tag == "B")
            begin
               br_from_q.push_back(a);
               br_to_q.push_back(d);
            end
            else
            begin
               $display("Unknown record type %s in the stim file", tag);
               stop_run();
            end
         end
      end
      $fclose(fd);
   endtask

   initial
   begin
      word_t      exp_fetch;
      logic [1:0] exp_phase;
      integer     done;
      int         order [16];
      int         j;
      int         t;
      reset_i   = 1'b1;
      test_rsel = '0;
      running   = 1'b0;
      n_inst    = 0;
      seed      = 32'h3962;
      for (int i = 0; i < 256; i++)
         mem[i] = 32'hA5000000 | i;
      for (int i = 0; i < 16; i++)
         exp_valid[i] = 1'b0;
      load_stim();
      repeat (16)
      begin
         @(negedge clk);
         expect_word("mbus_wen_o", mbus_wen, 0);
         expect_word("phase_o", phase, PH_FETCH);
         expect_word("mbus_addr_o", mbus_addr, 0);
      end
      reset_i   = 1'b0;
      running   = 1'b1;
      exp_fetch = '0;
      exp_phase = PH_FETCH;
      done      = 0;
      while (done < n_inst)
      begin
         expect_word("phase_o", phase, exp_phase);
         if (phase != PH_MEM)
            expect_word("mbus_wen_o", mbus_wen, 0);
         if (phase == PH_FETCH)
         begin
            expect_word("mbus_addr_o", mbus_addr, exp_fetch);
            exp_fetch = next_fetch(exp_fetch);
         end
         else if (phase == PH_MEM && mbus_wen)
            check_store();
         else if (phase == PH_WB)
            done++;
         exp_phase = exp_phase + 1'b1; // wraps back to fetch
         @(negedge clk);
      end
      for (int i = 0; i < 16; i++)
         order[i] = i;
      for (int i = 15; i > 0; i--)
      begin
         j        = $unsigned($random(seed)) % (i + 1);
         t        = order[i];
         order[i] = order[j];
         order[j] = t;
      end
      // program now spins on one instruction that only writes r15
      for (int i = 0; i < 16; i++)
      begin
         test_rsel = order[i];
         #2;
         if (exp_valid[order[i]])
            expect_word($sformatf("test_reg_o (r%0d)", order[i]), test_reg, exp_reg[order[i]]);
         @(negedge clk);
      end
      assert (st_addr_q.size() == 0)
      else
         $display("%0d expected stores never appeared on the bus", st_addr_q.size());
      if (st_addr_q.size() == 0)
      begin
         $display("All checks passed");
         $finish;
      end
      else
         stop_run();
   end

   initial
   begin
      wait (running);
      repeat (n_inst * 4 + 100) @(posedge clk);
      $display("Timeout: %0d instructions did not complete in time", n_inst);
      stop_run();
   end

endmodule
